/* dodge_game.f */
game_pkg.sv
game_apb_regs.sv
obstacle_field.sv
game_ctrl.sv
dodge_game_top.sv
dodge_game_tb.sv

/* Bender.yml */
package:
  name: dodge_game

sources:
  - game_pkg.sv
  - game_apb_regs.sv
  - obstacle_field.sv
  - game_ctrl.sv
  - dodge_game_top.sv
  - target: simulation
    files:
      - dodge_game_tb.sv

/* dodge_game_tb.sv */
// Dodge game testbench
// Drives the APB slave with LFSR stimulus and checks reads against a cycle model

`timescale 1ns/100ps
`default_nettype none

module dodge_game_tb
	import game_pkg::*;
();

	localparam int          CLK_PERIOD = 100;
	localparam logic [31:0] SEED       = 32'h5bc1;

	// Cycle budgets per test
	localparam int BUDGET_RESET  = 150;
	localparam int BUDGET_ERRORS = 300;
	localparam int BUDGET_MOVES  = 600;
	localparam int BUDGET_FRAME  = 2000;
	localparam int BUDGET_CRASH  = 1500;
	localparam int BUDGET_WIN    = LEVELS * LEVEL_STEPS * STEP_CYCLES + 400;
	localparam int CYCLE_LIMIT   = 2 * (BUDGET_RESET + BUDGET_ERRORS + BUDGET_MOVES
		+ BUDGET_FRAME + BUDGET_CRASH + BUDGET_WIN);

	logic              clock_50;
	logic              arst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic              pready;
	logic              pslverr;

	int          n_checks;
	int          n_errors;
	int          cycle_count = 0;
	logic [31:0] lfsr_state;

	// Model registers and their values for the next edge
	state_e                    m_state, n_state;
	logic [1:0]                m_lives, n_lives;
	logic [LEVEL_W-1:0]        m_level, n_level;
	logic [SCORE_W-1:0]        m_score, n_score;
	logic [ROW_W-1:0]          m_row, n_row;
	logic [COL_W-1:0]          m_col, n_col;
	int                        m_timer, n_timer;
	int                        m_lsteps, n_lsteps;
	logic [ROWS-1:0][COLS-1:0] m_rows, n_rows;
	logic                      m_cv;
	logic [2:0]                m_cmd;

	dodge_game_top dodge_game_top_inst (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr)
	);

	initial begin
		clock_50 = 1'b0;
		forever #(CLK_PERIOD / 2) clock_50 = ~clock_50;
	end

	always @(posedge clock_50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//########################################
	// Random numbers
	//########################################
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	//########################################
	// Game model
	//########################################
	task automatic model_next;
		logic tick;
		int   i;
		n_state  = m_state;
		n_lives  = m_lives;
		n_level  = m_level;
		n_score  = m_score;
		n_row    = m_row;
		n_col    = m_col;
		n_timer  = m_timer;
		n_lsteps = m_lsteps;
		n_rows   = m_rows;
		tick     = (m_timer == STEP_CYCLES - 1);
		if (m_cv && m_cmd == CMD_START) begin
			n_state  = ST_RUNNING;
			n_lives  = LIVES_INIT;
			n_level  = '0;
			n_score  = '0;
			n_timer  = 0;
			n_lsteps = 0;
			n_row    = START_ROW;
			n_col    = START_COL;
			n_rows   = LEVEL_PATTERNS[0];
		end else if (m_state == ST_RUNNING) begin
			n_timer = tick ? 0 : m_timer + 1;
			if (m_rows[m_row][m_col]) begin
				// Crash, reload the same level
				n_lives = m_lives - 1'b1;
				if (n_lives == 2'd0)
					n_state = ST_LOST;
				n_rows   = LEVEL_PATTERNS[m_level];
				n_row    = START_ROW;
				n_col    = START_COL;
				n_lsteps = 0;
			end else begin
				if (m_cv) begin
					case (m_cmd)
						CMD_UP:    if (m_row != ROWS - 1) n_row = m_row + 1'b1;
						CMD_DOWN:  if (m_row != 0) n_row = m_row - 1'b1;
						CMD_LEFT:  if (m_col != COLS - 1) n_col = m_col + 1'b1;
						CMD_RIGHT: if (m_col != 0) n_col = m_col - 1'b1;
						default: ;
					endcase
				end
				if (tick) begin
					if (m_score != 8'hff)
						n_score = m_score + 1'b1;
					if (m_lsteps + 1 == LEVEL_STEPS) begin
						n_lsteps = 0;
						n_row    = START_ROW;
						n_col    = START_COL;
						if (m_level == LEVELS - 1) begin
							n_state = ST_WON;
						end else begin
							n_level = m_level + 1'b1;
							n_rows  = LEVEL_PATTERNS[n_level];
						end
					end else begin
						n_lsteps = m_lsteps + 1;
						for (i = 0; i < ROWS; i++)
							n_rows[i] = m_rows[(i + 1) % ROWS];
					end
				end
			end
		end
	endtask

	always @(posedge clock_50) begin
		if (!arst_n) begin
			m_state  = ST_IDLE;
			m_lives  = '0;
			m_level  = '0;
			m_score  = '0;
			m_row    = START_ROW;
			m_col    = START_COL;
			m_timer  = 0;
			m_lsteps = 0;
			m_rows   = '0;
			m_cv     = 1'b0;
			m_cmd    = '0;
		end else begin
			m_state  = n_state;
			m_lives  = n_lives;
			m_level  = n_level;
			m_score  = n_score;
			m_row    = n_row;
			m_col    = n_col;
			m_timer  = n_timer;
			m_lsteps = n_lsteps;
			m_rows   = n_rows;
			// Command pulse from a completed write of a known opcode
			m_cv  = psel && penable && pwrite && paddr == ADDR_CMD
				&& pwdata >= CMD_START && pwdata <= CMD_RIGHT;
			m_cmd = pwdata[2:0];
		end
		model_next();
	end

	// STATUS level shows the incoming level on a load edge
	function automatic logic [DATA_W-1:0] expected_reg(input logic [ADDR_W-1:0] addr);
		logic [COLS-1:0] row;
		int              idx;
		idx = int'(addr) - int'(ADDR_ROW0);
		if (addr == ADDR_STATUS)
			return {2'b00, m_lives, n_level, m_state};
		if (addr == ADDR_SCORE)
			return m_score;
		if (addr == ADDR_POS)
			return {2'b00, m_row, m_col};
		if (idx >= 0 && idx < ROWS) begin
			row = m_rows[idx];
			if (idx == m_row)
				row[m_col] = 1'b1;
			return row;
		end
		return '0;
	endfunction

	//########################################
	// Bus and check helpers
	//########################################
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, got);
			n_errors++;
		end
	endtask

	task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
			output logic err, output logic [DATA_W-1:0] exp);
		// Setup phase
		@(posedge clock_50);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clock_50);
		penable <= 1'b1;
		// Sample mid access cycle
		@(negedge clock_50);
		rdata = prdata;
		err   = pslverr;
		exp   = expected_reg(addr);
		if (pready !== 1'b1) begin
			$display("Bus failure at %0t: pready was low during an access", $time);
			n_errors++;
		end
		@(posedge clock_50);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input string name,
			output logic [DATA_W-1:0] data);
		logic             err;
		logic [DATA_W-1:0] exp;
		bus_access(1'b0, addr, '0, data, err, exp);
		check_value(name, data, exp);
		check_value("pslverr", err, 1'b0);
	endtask

	task automatic write_cmd(input logic [2:0] op);
		logic              err;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] exp;
		bus_access(1'b1, ADDR_CMD, DATA_W'(op), data, err, exp);
		check_value("pslverr", err, 1'b0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock_50);
	endtask

	task automatic read_frame;
		logic [DATA_W-1:0] data;
		int                r;
		for (r = 0; r < ROWS; r++)
			read_check(ADDR_ROW0 + ADDR_W'(r), $sformatf("row%0d", r), data);
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s finished with %0d errors", name, n_errors - errors_before);
	endtask

	function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
		return addr <= ADDR_POS || (addr >= ADDR_ROW0 && addr < ADDR_ROW0 + ROWS);
	endfunction

	// Closest free column in the next obstacle row that is on its way
	function automatic int pick_column();
		logic [COLS-1:0] ahead;
		int              k;
		int              c;
		int              best;
		int              best_d;
		ahead  = '0;
		best   = m_col;
		best_d = COLS;
		for (k = ROWS - 1; k >= 1; k--)
			if (m_rows[k] != '0)
				ahead = m_rows[k];
		if (ahead == '0)
			return m_col;
		for (c = 0; c < COLS; c++) begin
			if (!ahead[c] && ((c > m_col) ? c - m_col : m_col - c) < best_d) begin
				best   = c;
				best_d = (c > m_col) ? c - m_col : m_col - c;
			end
		end
		return best;
	endfunction

	//########################################
	// Tests
	//########################################
	task automatic check_reset_state;
		logic [DATA_W-1:0] data;
		int                r;
		int                errs;
		errs = n_errors;
		read_check(ADDR_STATUS, "status", data);
		check_value("status", data, 8'h00);
		read_check(ADDR_SCORE, "score", data);
		check_value("score", data, 8'h00);
		read_check(ADDR_POS, "pos", data);
		check_value("pos", data, {START_ROW, START_COL});
		for (r = 0; r < ROWS; r++) begin
			read_check(ADDR_ROW0 + ADDR_W'(r), $sformatf("row%0d", r), data);
			check_value($sformatf("row%0d", r), data,
				(r == START_ROW) ? (8'h01 << START_COL) : 8'h00);
		end
		report_test("after reset", errs);
	endtask

	task automatic check_bus_errors;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] exp;
		logic [31:0]       v;
		logic              err;
		int                i;
		int                errs;
		errs = n_errors;
		for (i = 0; i < 6; i++) begin
			take_bits(5, v);
			while (is_mapped(v[4:0]))
				take_bits(5, v);
			bus_access(1'b0, v[4:0], '0, data, err, exp);
			check_value("pslverr", err, 1'b1);
		end
		bus_access(1'b0, ADDR_CMD, '0, data, err, exp);
		check_value("pslverr", err, 1'b1);
		for (i = 0; i < 6; i++) begin
			take_bits(12, v);
			bus_access(1'b1, (v[3:0] < 3) ? ADDR_W'(v[3:0] + 1) : ADDR_ROW0 + v[2:0],
				v[11:4], data, err, exp);
			check_value("pslverr", err, 1'b1);
		end
		read_check(ADDR_STATUS, "status", data);
		check_value("status", data, 8'h00);
		write_cmd(CMD_UP);
		write_cmd(CMD_LEFT);
		read_check(ADDR_POS, "pos", data);
		check_value("pos", data, {START_ROW, START_COL});
		write_cmd(CMD_DOWN);
		write_cmd(CMD_RIGHT);
		read_check(ADDR_POS, "pos", data);
		check_value("pos", data, {START_ROW, START_COL});
		report_test("bus errors", errs);
	endtask

	task automatic play_random_moves;
		logic [DATA_W-1:0] data;
		logic [31:0]       v;
		int                i;
		int                errs;
		errs = n_errors;
		write_cmd(CMD_START);
		@(posedge clock_50);
		for (i = 0; i < 40; i++) begin
			@(negedge clock_50);
			if (m_state != ST_RUNNING || m_lives != LIVES_INIT || m_level != 0)
				break;
			take_bits(2, v);
			write_cmd(3'(CMD_UP) + v[1:0]);
			take_bits(2, v);
			idle_cycles(v[1:0]);
			read_check(ADDR_POS, "pos", data);
		end
		report_test("movement", errs);
	endtask

	task automatic check_frame_and_score;
		logic [DATA_W-1:0] data;
		logic [31:0]       v;
		int                i;
		int                errs;
		errs = n_errors;
		write_cmd(CMD_START);
		for (i = 0; i < 40; i++) begin
			@(negedge clock_50);
			if (m_state != ST_RUNNING)
				write_cmd(CMD_START);
			take_bits(2, v);
			case (v[1:0])
				2'd0: read_frame();
				2'd1: read_check(ADDR_SCORE, "score", data);
				default: begin
					take_bits(2, v);
					write_cmd(3'(CMD_UP) + v[1:0]);
				end
			endcase
			take_bits(2, v);
			idle_cycles(v[1:0]);
		end
		report_test("scrolling and score", errs);
	endtask

	task automatic run_crashes;
		logic [DATA_W-1:0] data;
		int                i;
		int                errs;
		errs = n_errors;
		write_cmd(CMD_START);
		@(posedge clock_50);
		for (i = 0; i < 100; i++) begin
			@(negedge clock_50);
			if (m_state != ST_RUNNING)
				break;
			write_cmd(CMD_UP);
			read_check(ADDR_STATUS, "status", data);
			read_check(ADDR_POS, "pos", data);
		end
		read_check(ADDR_STATUS, "status", data);
		check_value("status.state", data[1:0], ST_LOST);
		check_value("status.lives", data[5:4], 2'd0);
		write_cmd(CMD_START);
		read_check(ADDR_STATUS, "status", data);
		check_value("status", data, {LIVES_INIT, 2'd0, ST_RUNNING});
		read_check(ADDR_SCORE, "score", data);
		check_value("score", data, 8'h00);
		report_test("crashes and restart", errs);
	endtask

	task automatic play_to_win;
		logic [DATA_W-1:0] data;
		int                i;
		int                target;
		int                next_col;
		int                level_seen;
		int                errs;
		errs       = n_errors;
		level_seen = 0;
		write_cmd(CMD_START);
		@(posedge clock_50);
		for (i = 0; i < BUDGET_WIN; i++) begin
			@(negedge clock_50);
			if (m_state != ST_RUNNING)
				break;
			target   = pick_column();
			next_col = (target > m_col) ? m_col + 1 : m_col - 1;
			// Moves issued early in a step period land before the next scroll
			if (target != m_col && m_timer <= STEP_CYCLES - 5 && !m_rows[0][next_col]) begin
				write_cmd((target > m_col) ? CMD_LEFT : CMD_RIGHT);
				@(posedge clock_50);
			end else if (m_level != level_seen) begin
				read_check(ADDR_STATUS, "status", data);
				level_seen = m_level;
			end
		end
		read_check(ADDR_STATUS, "status", data);
		check_value("status", data, {LIVES_INIT, LEVEL_W'(LEVELS - 1), ST_WON});
		read_check(ADDR_SCORE, "score", data);
		check_value("score", data, LEVELS * LEVEL_STEPS);
		report_test("level advance and win", errs);
	endtask

	//########################################
	// Main sequence
	//########################################
	initial begin
		n_checks   = 0;
		n_errors   = 0;
		lfsr_state = SEED;
		arst_n     = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		repeat (5) @(posedge clock_50);
		arst_n <= 1'b1;

		check_reset_state();
		check_bus_errors();
		play_random_moves();
		check_frame_and_score();
		run_crashes();
		play_to_win();

		$display("%0d checks done, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dodge_game_top.sv */
// Dodge game top level
// APB slave, game controller and obstacle field

`timescale 1ns/100ps
`default_nettype none

module dodge_game_top
	import game_pkg::*;
(
	input  logic              clock_50,
	input  logic              arst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output logic              pslverr
);

	cmd_e                      cmd;
	logic                      cmd_valid;
	logic                      field_load;
	logic                      step;
	logic [LEVEL_W-1:0]        level;
	state_e                    state;
	logic [1:0]                lives;
	logic [SCORE_W-1:0]        score;
	logic [ROW_W-1:0]          pos_row;
	logic [COL_W-1:0]          pos_col;
	logic [ROWS-1:0][COLS-1:0] rows;

	//########################################
	// Bus slave
	//########################################
	game_apb_regs game_apb_regs_u0 (
		.clock_50  (clock_50),
		.arst_n    (arst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.state     (state),
		.lives     (lives),
		.level     (level),
		.score     (score),
		.pos_row   (pos_row),
		.pos_col   (pos_col),
		.rows      (rows)
	);

	//########################################
	// Game core
	//########################################
	game_ctrl game_ctrl_u0 (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.rows       (rows),
		.field_load (field_load),
		.step       (step),
		.level      (level),
		.state      (state),
		.lives      (lives),
		.score      (score),
		.pos_row    (pos_row),
		.pos_col    (pos_col)
	);

	obstacle_field obstacle_field_u0 (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.field_load (field_load),
		.step       (step),
		.level      (level),
		.rows       (rows)
	);

endmodule

`default_nettype wire

/* game_ctrl.sv */
// Dodge game controller
// State machine, step timer, player position, lives, level, score and crash test

`timescale 1ns/100ps
`default_nettype none

module game_ctrl
	import game_pkg::*;
(
	input  logic                      clock_50,
	input  logic                      arst_n,
	input  cmd_e                      cmd,
	input  logic                      cmd_valid,
	input  logic [ROWS-1:0][COLS-1:0] rows,
	output logic                      field_load,
	output logic                      step,
	output logic [LEVEL_W-1:0]        level,
	output state_e                    state,
	output logic [1:0]                lives,
	output logic [SCORE_W-1:0]        score,
	output logic [ROW_W-1:0]          pos_row,
	output logic [COL_W-1:0]          pos_col
);

	state_e                             state_q, state_d;
	logic [1:0]                         lives_q, lives_d;
	logic [LEVEL_W-1:0]                 level_q, level_d;
	logic [SCORE_W-1:0]                 score_q, score_d;
	logic [ROW_W-1:0]                   row_q, row_d;
	logic [COL_W-1:0]                   col_q, col_d;
	logic [$clog2(STEP_CYCLES)-1:0]     timer_q, timer_d;
	logic [$clog2(LEVEL_STEPS+1)-1:0]   lsteps_q, lsteps_d;

	logic start;
	logic step_tick;
	logic crash;

	assign start     = cmd_valid && (cmd == CMD_START);
	assign step_tick = (timer_q == STEP_CYCLES - 1);
	// Only place where the player meets the field
	assign crash     = rows[row_q][col_q];

	//########################################
	// Next state
	//########################################
	always_comb begin
		state_d    = state_q;
		lives_d    = lives_q;
		level_d    = level_q;
		score_d    = score_q;
		row_d      = row_q;
		col_d      = col_q;
		timer_d    = timer_q;
		lsteps_d   = lsteps_q;
		field_load = 1'b0;
		step       = 1'b0;

		if (start) begin
			// Restart from any state
			state_d    = ST_RUNNING;
			lives_d    = LIVES_INIT;
			level_d    = '0;
			score_d    = '0;
			timer_d    = '0;
			lsteps_d   = '0;
			row_d      = START_ROW;
			col_d      = START_COL;
			field_load = 1'b1;
		end else if (state_q == ST_RUNNING) begin
			// Timer free-runs through crashes and level changes
			timer_d = step_tick ? '0 : timer_q + 1'b1;

			if (crash) begin
				lives_d = lives_q - 1'b1;
				if (lives_q == 2'd1) begin
					state_d = ST_LOST;
				end
				row_d      = START_ROW;
				col_d      = START_COL;
				lsteps_d   = '0;
				field_load = 1'b1;
			end else begin
				// Moves stop at the grid edge
				if (cmd_valid) begin
					case (cmd)
						CMD_UP:    if (row_q != ROW_W'(ROWS - 1)) row_d = row_q + 1'b1;
						CMD_DOWN:  if (row_q != '0) row_d = row_q - 1'b1;
						CMD_LEFT:  if (col_q != COL_W'(COLS - 1)) col_d = col_q + 1'b1;
						CMD_RIGHT: if (col_q != '0) col_d = col_q - 1'b1;
						default: ;
					endcase
				end

				if (step_tick) begin
					if (score_q != '1) begin
						score_d = score_q + 1'b1;
					end
					if (lsteps_q == LEVEL_STEPS - 1) begin
						// Level cleared, no scroll on this step
						lsteps_d = '0;
						row_d    = START_ROW;
						col_d    = START_COL;
						if (level_q == LEVEL_W'(LEVELS - 1)) begin
							state_d = ST_WON;
						end else begin
							level_d    = level_q + 1'b1;
							field_load = 1'b1;
						end
					end else begin
						lsteps_d = lsteps_q + 1'b1;
						step     = 1'b1;
					end
				end
			end
		end
	end

	//########################################
	// Registers
	//########################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state_q  <= ST_IDLE;
			lives_q  <= '0;
			level_q  <= '0;
			score_q  <= '0;
			row_q    <= START_ROW;
			col_q    <= START_COL;
			timer_q  <= '0;
			lsteps_q <= '0;
		end else begin
			state_q  <= state_d;
			lives_q  <= lives_d;
			level_q  <= level_d;
			score_q  <= score_d;
			row_q    <= row_d;
			col_q    <= col_d;
			timer_q  <= timer_d;
			lsteps_q <= lsteps_d;
		end
	end

	// Field loads on the same edge, so it needs the incoming level
	assign level   = level_d;
	assign state   = state_q;
	assign lives   = lives_q;
	assign score   = score_q;
	assign pos_row = row_q;
	assign pos_col = col_q;

endmodule

`default_nettype wire

/* obstacle_field.sv */
// Obstacle field of eight row registers
// Loads a level table and rotates the rows toward row 0 on every step

`timescale 1ns/100ps
`default_nettype none

module obstacle_field
	import game_pkg::*;
(
	input  logic                      clock_50,
	input  logic                      arst_n,
	input  logic                      field_load,
	input  logic                      step,
	input  logic [LEVEL_W-1:0]        level,
	output logic [ROWS-1:0][COLS-1:0] rows
);

	logic [ROWS-1:0][COLS-1:0] rows_q;
	logic [ROWS-1:0][COLS-1:0] rows_rot;

	// Row i takes row i+1, row 7 wraps around from row 0
	assign rows_rot = {rows_q[0], rows_q[ROWS-1:1]};

	//########################################
	// Row registers
	//########################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			rows_q <= '0;
		end else if (field_load) begin
			// Reload beats scroll
			rows_q <= LEVEL_PATTERNS[level];
		end else if (step) begin
			rows_q <= rows_rot;
		end
	end

	assign rows = rows_q;

endmodule

`default_nettype wire

/* game_apb_regs.sv */
// Dodge game APB slave
// Turns command writes into one-cycle pulses, serves status, score, position and frame rows

`timescale 1ns/100ps
`default_nettype none

module game_apb_regs
	import game_pkg::*;
(
	input  logic                      clock_50,
	input  logic                      arst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [ADDR_W-1:0]         paddr,
	input  logic [DATA_W-1:0]         pwdata,
	output logic [DATA_W-1:0]         prdata,
	output logic                      pready,
	output logic                      pslverr,
	output cmd_e                      cmd,
	output logic                      cmd_valid,
	input  state_e                    state,
	input  logic [1:0]                lives,
	input  logic [LEVEL_W-1:0]        level,
	input  logic [SCORE_W-1:0]        score,
	input  logic [ROW_W-1:0]          pos_row,
	input  logic [COL_W-1:0]          pos_col,
	input  logic [ROWS-1:0][COLS-1:0] rows
);

	logic              access;
	logic              is_cmd;
	logic              is_status;
	logic              is_score;
	logic              is_pos;
	logic              is_row;
	logic              is_readable;
	logic              wr_cmd;
	logic              op_ok;
	logic [ADDR_W-1:0] row_off;
	logic [ROW_W-1:0]  row_idx;
	logic [COLS-1:0]   player_mask;
	logic [COLS-1:0]   frame_row;

	//########################################
	// Address decode
	//########################################
	assign access = psel & penable;

	assign is_cmd    = (paddr == ADDR_CMD);
	assign is_status = (paddr == ADDR_STATUS);
	assign is_score  = (paddr == ADDR_SCORE);
	assign is_pos    = (paddr == ADDR_POS);

	// Addresses below ADDR_ROW0 wrap to a large offset and fall out of range
	assign row_off = paddr - ADDR_ROW0;
	assign row_idx = row_off[ROW_W-1:0];
	assign is_row  = (row_off < ADDR_W'(ROWS));

	assign is_readable = is_status | is_score | is_pos | is_row;

	// Zero wait states
	assign pready = 1'b1;

	// Command is write-only, everything else read-only
	assign pslverr = access & (pwrite ? ~is_cmd : ~is_readable);

	//########################################
	// Command pulse
	//########################################
	assign wr_cmd = access & pwrite & is_cmd;
	// NOP and unknown opcodes are accepted but never reach the controller
	assign op_ok  = (pwdata <= DATA_W'(CMD_RIGHT)) && (pwdata != DATA_W'(CMD_NOP));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= wr_cmd & op_ok;
		end
	end

	always_ff @(posedge clock_50) begin
		if (wr_cmd && op_ok) begin
			cmd <= cmd_e'(pwdata[$bits(cmd_e)-1:0]);
		end
	end

	//########################################
	// Read data
	//########################################
	// Player dot overlaid on the addressed obstacle row, bit 7 is leftmost
	assign player_mask = {{(COLS-1){1'b0}}, 1'b1} << pos_col;
	assign frame_row   = rows[row_idx] | ((row_idx == pos_row) ? player_mask : '0);

	always_comb begin
		prdata = '0;
		if (is_status) begin
			prdata = DATA_W'({lives, level, state});
		end else if (is_score) begin
			prdata = DATA_W'(score);
		end else if (is_pos) begin
			prdata = DATA_W'({pos_row, pos_col});
		end else if (is_row) begin
			prdata = DATA_W'(frame_row);
		end
	end

endmodule

`default_nettype wire

/* game_pkg.sv */
// Dodge game shared definitions
// Grid and timing constants, level obstacle tables, register map and enums

`default_nettype none

package game_pkg;

	//########################################
	// Grid and timing
	//########################################
	localparam int ROWS  = 8;
	localparam int COLS  = 8;
	localparam int ROW_W = 3;
	localparam int COL_W = 3;

	localparam int LEVELS  = 4;
	localparam int LEVEL_W = 2;

	localparam logic [1:0] LIVES_INIT = 2'd3;

	// Clock cycles per scroll step
	localparam int STEP_CYCLES = 16;
	// Steps survived before the next level loads
	localparam int LEVEL_STEPS = 12;

	localparam int SCORE_W = 8;

	localparam logic [ROW_W-1:0] START_ROW = 3'd0;
	localparam logic [COL_W-1:0] START_COL = 3'd4;

	//########################################
	// Level obstacle tables
	//########################################
	// Each level lists row 7 first, down to row 0
	// Row 0 is always empty so a reload never lands on an obstacle
	localparam logic [LEVELS-1:0][ROWS-1:0][COLS-1:0] LEVEL_PATTERNS = {
		// Level 4
		8'b11101101, 8'b01010101, 8'b00000000, 8'b11011011,
		8'b00000000, 8'b11111110, 8'b00000000, 8'b00000000,
		// Level 3
		8'b11101101, 8'b11000110, 8'b00000000, 8'b11110000,
		8'b00000000, 8'b11000110, 8'b00000000, 8'b00000000,
		// Level 2
		8'b10101111, 8'b11000000, 8'b00000000, 8'b00011100,
		8'b00000000, 8'b00001110, 8'b00000000, 8'b00000000,
		// Level 1
		8'b11101101, 8'b00001100, 8'b00000000, 8'b11000000,
		8'b00000000, 8'b00011000, 8'b00000000, 8'b00000000
	};

	//########################################
	// APB register map
	//########################################
	localparam int ADDR_W = 5;
	localparam int DATA_W = 8;

	localparam logic [ADDR_W-1:0] ADDR_CMD    = 5'd0;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'd1;
	localparam logic [ADDR_W-1:0] ADDR_SCORE  = 5'd2;
	localparam logic [ADDR_W-1:0] ADDR_POS    = 5'd3;
	// Frame rows sit at ADDR_ROW0 up to ADDR_ROW0 + 7
	localparam logic [ADDR_W-1:0] ADDR_ROW0   = 5'd8;

	//########################################
	// Enums
	//########################################
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_RUNNING = 2'd1,
		ST_WON     = 2'd2,
		ST_LOST    = 2'd3
	} state_e;

	typedef enum logic [2:0] {
		CMD_NOP   = 3'd0,
		CMD_START = 3'd1,
		CMD_UP    = 3'd2,
		CMD_DOWN  = 3'd3,
		CMD_LEFT  = 3'd4,
		CMD_RIGHT = 3'd5
	} cmd_e;

endpackage

`default_nettype wire
